// File: files.f
source/avr_io_pkg.sv
source/io_addr_decode.sv
source/pport.sv
source/timer_counter0.sv
source/io_read_mux.sv
source/peripherals.sv
sim/tb_peripherals.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_peripherals -f files.f \
   -o tb_peripherals_sim || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_peripherals_sim)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// File: sim/tb_peripherals.sv
module tb_peripherals;

   timeunit 1ns;
   timeprecision 1ns;

   import avr_io_pkg::*;

   logic     cp2;
   logic     reset;
   io_addr_t adr;
   logic     iore;
   logic     iowe;
   io_data_t dbus_in;
   io_data_t dbus_out;
   logic     out_en;
   irq_vec_t irqlines;
   irq_vec_t irq_ack;
   logic     ext_irq1;
   io_data_t porta_portx;
   io_data_t porta_ddrx;
   io_data_t porta_pinx;
   io_data_t portb_portx;
   io_data_t portb_ddrx;
   io_data_t portb_pinx;

   integer   seed = 32'h8ca8;
   string    test_name;
   int       error_count = 0;
   int       check_count = 0;
   int       test_count = 0;
   int       start_errors = 0;
   logic     timed_out = 1'b0;

   // Expected port register contents, kept across tests
   io_data_t exp_porta;
   io_data_t exp_ddra;
   io_data_t exp_portb;
   io_data_t exp_ddrb;

   peripherals #(
      .port_width (8)
   ) peripherals_inst (
      .cp2         (cp2),
      .reset       (reset),
      .adr         (adr),
      .iore        (iore),
      .iowe        (iowe),
      .dbus_in     (dbus_in),
      .dbus_out    (dbus_out),
      .out_en      (out_en),
      .irqlines    (irqlines),
      .irq_ack     (irq_ack),
      .ext_irq1    (ext_irq1),
      .porta_portx (porta_portx),
      .porta_ddrx  (porta_ddrx),
      .porta_pinx  (porta_pinx),
      .portb_portx (portb_portx),
      .portb_ddrx  (portb_ddrx),
      .portb_pinx  (portb_pinx)
   );

   always #50 cp2 = ~cp2;

   // =========================================================================
   // Bus access and checking
   // =========================================================================

   task automatic io_write(input io_addr_t a, input io_data_t d);
      @(negedge cp2);
      adr     = a;
      dbus_in = d;
      iowe    = 1'b1;
      @(negedge cp2);
      iowe    = 1'b0;
   endtask

   // Read data is combinational, sampled well before the next rising edge
   task automatic io_read(input io_addr_t a, output io_data_t d, output logic en);
      @(negedge cp2);
      adr  = a;
      iore = 1'b1;
      #10;
      d    = dbus_out;
      en   = out_en;
      iore = 1'b0;
   endtask

   task automatic check_data(input string what, input io_data_t exp, input io_data_t act);
      check_count++;
      if (act !== exp) begin
         $display("error %s %s: expected 0x%02h, actual 0x%02h", test_name, what, exp, act);
         error_count++;
      end
   endtask

   task automatic check_irq(input string what, input irq_vec_t exp, input irq_vec_t act);
      check_count++;
      if (act !== exp) begin
         $display("error %s %s: expected 0x%06h, actual 0x%06h", test_name, what, exp, act);
         error_count++;
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
         error_count++;
      end
   endtask

   // Read a register and compare, out_en must be high for a mapped address
   task automatic read_check(input string what, input io_addr_t a, input io_data_t exp);
      io_data_t d;
      logic     en;
      io_read(a, d, en);
      check_flag({what, " out_en"}, 1'b1, en);
      check_data(what, exp, d);
   endtask

   // Poll one interrupt line on falling edges
   task automatic wait_irq(input int line, input logic level, input int max_cycles);
      int n;
      n = 0;
      while (irqlines[line] !== level && n < max_cycles) begin
         @(negedge cp2);
         n++;
      end
      if (irqlines[line] !== level) begin
         $display("timeout in %s: interrupt line %0d did not go to %b within %0d cycles",
                  test_name, line, level, max_cycles);
         timed_out = 1'b1;
         error_count++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name    = name;
      start_errors = error_count;
   endtask

   task automatic end_test();
      test_count++;
      if (error_count == start_errors) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, error_count - start_errors);
      end
   endtask

   // =========================================================================
   // Directed tests
   // =========================================================================

   task automatic test_reset_state();
      irq_vec_t exp_irq;
      io_data_t d;
      logic     en;
      begin_test("reset_state");
      exp_irq           = '0;
      exp_irq[IRQ_EXT1] = ext_irq1;
      check_irq("irqlines", exp_irq, irqlines);
      check_data("porta_portx", 8'h00, porta_portx);
      check_data("porta_ddrx", 8'h00, porta_ddrx);
      check_data("portb_portx", 8'h00, portb_portx);
      check_data("portb_ddrx", 8'h00, portb_ddrx);
      read_check("tccr0", TCCR0_ADR, 8'h00);
      read_check("tifr", TIFR_ADR, 8'h00);
      io_read(6'h00, d, en);
      check_flag("unmapped out_en", 1'b0, en);
      check_data("unmapped dbus_out", 8'h00, d);
      end_test();
   endtask

   task automatic test_port_registers();
      begin_test("port_registers");
      exp_porta = io_data_t'($random(seed));
      exp_ddra  = io_data_t'($random(seed));
      exp_portb = io_data_t'($random(seed));
      exp_ddrb  = io_data_t'($random(seed));
      io_write(PORTA_ADR, exp_porta);
      io_write(DDRA_ADR, exp_ddra);
      io_write(PORTB_ADR, exp_portb);
      io_write(DDRB_ADR, exp_ddrb);
      read_check("porta", PORTA_ADR, exp_porta);
      read_check("ddra", DDRA_ADR, exp_ddra);
      read_check("portb", PORTB_ADR, exp_portb);
      read_check("ddrb", DDRB_ADR, exp_ddrb);
      check_data("porta_portx", exp_porta, porta_portx);
      check_data("porta_ddrx", exp_ddra, porta_ddrx);
      check_data("portb_portx", exp_portb, portb_portx);
      check_data("portb_ddrx", exp_ddrb, portb_ddrx);
      // A second port A write must not reach port B
      exp_porta = ~exp_porta;
      io_write(PORTA_ADR, exp_porta);
      read_check("porta rewrite", PORTA_ADR, exp_porta);
      read_check("ddra kept", DDRA_ADR, exp_ddra);
      read_check("portb kept", PORTB_ADR, exp_portb);
      read_check("ddrb kept", DDRB_ADR, exp_ddrb);
      check_data("portb_portx kept", exp_portb, portb_portx);
      end_test();
   endtask

   task automatic test_pin_sync();
      io_data_t pa;
      io_data_t pb;
      begin_test("pin_sync");
      pa = io_data_t'($random(seed));
      pb = io_data_t'($random(seed));
      @(negedge cp2);
      porta_pinx = pa;
      portb_pinx = pb;
      repeat (2) @(negedge cp2);
      read_check("pina", PINA_ADR, pa);
      read_check("pinb", PINB_ADR, pb);
      io_write(PINA_ADR, ~pa);
      read_check("pina after write", PINA_ADR, pa);
      read_check("porta after pina write", PORTA_ADR, exp_porta);
      read_check("ddra after pina write", DDRA_ADR, exp_ddra);
      end_test();
   endtask

   task automatic test_overflow_irq();
      begin_test("overflow_irq");
      io_write(TCNT0_ADR, 8'hF0);
      io_write(TCCR0_ADR, {5'b0, CS_DIV1});
      wait_irq(IRQ_TC0_OVF, 1'b1, 100);
      io_write(TCCR0_ADR, {5'b0, CS_STOP});
      // OCR0 is still zero, so the step to 0x00 also sets OCF0
      read_check("tifr after overflow", TIFR_ADR, 8'h03);
      @(negedge cp2);
      irq_ack[IRQ_TC0_OVF] = 1'b1;
      @(negedge cp2);
      irq_ack[IRQ_TC0_OVF] = 1'b0;
      check_flag("ovf line after ack", 1'b0, irqlines[IRQ_TC0_OVF]);
      read_check("tifr after ack", TIFR_ADR, 8'h02);
      end_test();
   endtask

   task automatic test_compare_irq();
      io_data_t d;
      logic     en;
      begin_test("compare_irq");
      // Leftover flags from the overflow run
      io_write(TIFR_ADR, 8'h03);
      check_flag("cmp line cleared", 1'b0, irqlines[IRQ_TC0_CMP]);
      io_write(OCR0_ADR, 8'h40);
      io_write(TCNT0_ADR, 8'h30);
      io_write(TCCR0_ADR, {5'b0, CS_DIV8});
      read_check("ocr0", OCR0_ADR, 8'h40);
      read_check("tccr0", TCCR0_ADR, {5'b0, CS_DIV8});
      wait_irq(IRQ_TC0_CMP, 1'b1, 400);
      io_read(TCNT0_ADR, d, en);
      check_flag("tcnt0 out_en", 1'b1, en);
      check_flag("tcnt0 not below ocr0", 1'b1, d >= 8'h40);
      io_write(TIFR_ADR, 8'h01 << OCF0_BIT);
      check_flag("cmp line after tifr write", 1'b0, irqlines[IRQ_TC0_CMP]);
      io_write(TCCR0_ADR, {5'b0, CS_STOP});
      end_test();
   endtask

   task automatic test_ext_and_stop();
      irq_vec_t exp_irq;
      begin_test("ext_and_stop");
      exp_irq = '0;
      @(negedge cp2);
      ext_irq1 = 1'b1;
      exp_irq[IRQ_EXT1] = 1'b1;
      #10;
      check_irq("ext_irq1 high", exp_irq, irqlines);
      @(negedge cp2);
      ext_irq1 = 1'b0;
      exp_irq[IRQ_EXT1] = 1'b0;
      #10;
      check_irq("ext_irq1 low", exp_irq, irqlines);
      // Run the timer, then stop it on a known count
      io_write(TCCR0_ADR, {5'b0, CS_DIV1});
      io_write(TCCR0_ADR, {5'b0, CS_STOP});
      io_write(TCNT0_ADR, 8'h5A);
      read_check("tcnt0 stopped first", TCNT0_ADR, 8'h5A);
      repeat (10) @(negedge cp2);
      read_check("tcnt0 stopped second", TCNT0_ADR, 8'h5A);
      end_test();
   endtask

   // =========================================================================
   // Main sequence
   // =========================================================================

   initial begin
      cp2        = 1'b0;
      reset      = 1'b1;
      adr        = '0;
      iore       = 1'b0;
      iowe       = 1'b0;
      dbus_in    = '0;
      irq_ack    = '0;
      ext_irq1   = 1'b0;
      porta_pinx = '0;
      portb_pinx = '0;
      repeat (5) @(negedge cp2);
      reset = 1'b0;

      test_reset_state();
      test_port_registers();
      test_pin_sync();
      if (!timed_out) begin
         test_overflow_irq();
      end
      if (!timed_out) begin
         test_compare_irq();
      end
      if (!timed_out) begin
         test_ext_and_stop();
      end

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0 && !timed_out) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: source/avr_io_pkg.sv
package avr_io_pkg;

   // =========================================================================
   // Bus and interrupt types
   // =========================================================================

   parameter int IRQS_WIDTH = 23;

   typedef logic [5:0]            io_addr_t;
   typedef logic [7:0]            io_data_t;
   typedef logic [IRQS_WIDTH-1:0] irq_vec_t;

   // Decoded registers, also the bit order of the select vectors
   typedef enum logic [3:0] {
      REG_PORTA,
      REG_DDRA,
      REG_PINA,
      REG_PORTB,
      REG_DDRB,
      REG_PINB,
      REG_TCCR0,
      REG_TCNT0,
      REG_OCR0,
      REG_TIFR
   } io_reg_e;

   parameter int NUM_IO_REGS = 10;

   typedef logic [NUM_IO_REGS-1:0] reg_sel_t;

   // =========================================================================
   // I/O register map
   // =========================================================================

   parameter io_addr_t PINB_ADR  = 6'h16;
   parameter io_addr_t DDRB_ADR  = 6'h17;
   parameter io_addr_t PORTB_ADR = 6'h18;
   parameter io_addr_t PINA_ADR  = 6'h19;
   parameter io_addr_t DDRA_ADR  = 6'h1A;
   parameter io_addr_t PORTA_ADR = 6'h1B;
   parameter io_addr_t OCR0_ADR  = 6'h31;
   parameter io_addr_t TCNT0_ADR = 6'h32;
   parameter io_addr_t TCCR0_ADR = 6'h33;
   parameter io_addr_t TIFR_ADR  = 6'h36;

   // Timer 0 clock select, codes 6 and 7 behave as stop
   typedef enum logic [2:0] {
      CS_STOP    = 3'd0,
      CS_DIV1    = 3'd1,
      CS_DIV8    = 3'd2,
      CS_DIV64   = 3'd3,
      CS_DIV256  = 3'd4,
      CS_DIV1024 = 3'd5
   } clk_sel_e;

   // TIFR flag positions
   parameter int TOV0_BIT = 0;
   parameter int OCF0_BIT = 1;

   // Interrupt line indices
   parameter int IRQ_TC0_OVF = 15;
   parameter int IRQ_TC0_CMP = 14;
   parameter int IRQ_EXT1    = 1;

endpackage

// File: source/io_addr_decode.sv
module io_addr_decode (
   input  avr_io_pkg::io_addr_t adr,
   input  logic                 iore,
   input  logic                 iowe,
   output avr_io_pkg::reg_sel_t wr_sel,
   output avr_io_pkg::reg_sel_t rd_sel
);

   import avr_io_pkg::*;

   reg_sel_t adr_hit;

   // =========================================================================
   // Address match, one bit per register
   // =========================================================================

   always_comb begin
      adr_hit = '0;
      case (adr)
         PORTA_ADR: begin
            adr_hit[REG_PORTA] = 1'b1;
         end
         DDRA_ADR: begin
            adr_hit[REG_DDRA] = 1'b1;
         end
         PINA_ADR: begin
            adr_hit[REG_PINA] = 1'b1;
         end
         PORTB_ADR: begin
            adr_hit[REG_PORTB] = 1'b1;
         end
         DDRB_ADR: begin
            adr_hit[REG_DDRB] = 1'b1;
         end
         PINB_ADR: begin
            adr_hit[REG_PINB] = 1'b1;
         end
         TCCR0_ADR: begin
            adr_hit[REG_TCCR0] = 1'b1;
         end
         TCNT0_ADR: begin
            adr_hit[REG_TCNT0] = 1'b1;
         end
         OCR0_ADR: begin
            adr_hit[REG_OCR0] = 1'b1;
         end
         TIFR_ADR: begin
            adr_hit[REG_TIFR] = 1'b1;
         end
         default: begin
            adr_hit = '0;
         end
      endcase
   end

   // Qualify with the strobes
   assign wr_sel = adr_hit & {NUM_IO_REGS{iowe}};
   assign rd_sel = adr_hit & {NUM_IO_REGS{iore}};

endmodule

// File: source/io_read_mux.sv
module io_read_mux (
   input  avr_io_pkg::reg_sel_t rd_sel,
   input  avr_io_pkg::io_data_t porta_val,
   input  avr_io_pkg::io_data_t ddra_val,
   input  avr_io_pkg::io_data_t pina_val,
   input  avr_io_pkg::io_data_t portb_val,
   input  avr_io_pkg::io_data_t ddrb_val,
   input  avr_io_pkg::io_data_t pinb_val,
   input  avr_io_pkg::io_data_t tccr0_val,
   input  avr_io_pkg::io_data_t tcnt0_val,
   input  avr_io_pkg::io_data_t ocr0_val,
   input  avr_io_pkg::io_data_t tifr_val,
   output avr_io_pkg::io_data_t dbus_out,
   output logic                 out_en
);

   import avr_io_pkg::*;

   io_data_t reg_val [NUM_IO_REGS];

   // Values in select bit order
   assign reg_val[REG_PORTA] = porta_val;
   assign reg_val[REG_DDRA]  = ddra_val;
   assign reg_val[REG_PINA]  = pina_val;
   assign reg_val[REG_PORTB] = portb_val;
   assign reg_val[REG_DDRB]  = ddrb_val;
   assign reg_val[REG_PINB]  = pinb_val;
   assign reg_val[REG_TCCR0] = tccr0_val;
   assign reg_val[REG_TCNT0] = tcnt0_val;
   assign reg_val[REG_OCR0]  = ocr0_val;
   assign reg_val[REG_TIFR]  = tifr_val;

   // AND-OR merge, at most one select is set
   always_comb begin
      dbus_out = '0;
      for (int i = 0; i < NUM_IO_REGS; i++) begin
         dbus_out = dbus_out | (reg_val[i] & {8{rd_sel[i]}});
      end
   end

   assign out_en = |rd_sel;

endmodule

// File: source/peripherals.sv
module peripherals #(
   parameter int port_width = 8
) (
   // Clock and reset
   input  logic                  cp2,
   input  logic                  reset,

   // CPU I/O bus
   input  avr_io_pkg::io_addr_t  adr,
   input  logic                  iore,
   input  logic                  iowe,
   input  avr_io_pkg::io_data_t  dbus_in,
   output avr_io_pkg::io_data_t  dbus_out,
   output logic                  out_en,

   // Interrupts
   output avr_io_pkg::irq_vec_t  irqlines,
   input  avr_io_pkg::irq_vec_t  irq_ack,
   input  logic                  ext_irq1,

   // Port A pins
   output logic [port_width-1:0] porta_portx,
   output logic [port_width-1:0] porta_ddrx,
   input  logic [port_width-1:0] porta_pinx,

   // Port B pins
   output logic [port_width-1:0] portb_portx,
   output logic [port_width-1:0] portb_ddrx,
   input  logic [port_width-1:0] portb_pinx
);

   import avr_io_pkg::*;

   reg_sel_t wr_sel;
   reg_sel_t rd_sel;

   io_data_t porta_val;
   io_data_t ddra_val;
   io_data_t pina_val;
   io_data_t portb_val;
   io_data_t ddrb_val;
   io_data_t pinb_val;
   io_data_t tccr0_val;
   io_data_t tcnt0_val;
   io_data_t ocr0_val;
   io_data_t tifr_val;

   logic tc0_ovf_irq;
   logic tc0_cmp_irq;

   // =========================================================================
   // Address decode
   // =========================================================================

   io_addr_decode io_addr_decode_inst (
      .adr    (adr),
      .iore   (iore),
      .iowe   (iowe),
      .wr_sel (wr_sel),
      .rd_sel (rd_sel)
   );

   // =========================================================================
   // Peripherals
   // =========================================================================

   pport #(
      .port_width (port_width)
   ) pport_a_inst (
      .cp2       (cp2),
      .reset     (reset),
      .dbus_in   (dbus_in),
      .portx_wr  (wr_sel[REG_PORTA]),
      .ddrx_wr   (wr_sel[REG_DDRA]),
      .pinx      (porta_pinx),
      .portx     (porta_portx),
      .ddrx      (porta_ddrx),
      .portx_val (porta_val),
      .ddrx_val  (ddra_val),
      .pinx_val  (pina_val)
   );

   pport #(
      .port_width (port_width)
   ) pport_b_inst (
      .cp2       (cp2),
      .reset     (reset),
      .dbus_in   (dbus_in),
      .portx_wr  (wr_sel[REG_PORTB]),
      .ddrx_wr   (wr_sel[REG_DDRB]),
      .pinx      (portb_pinx),
      .portx     (portb_portx),
      .ddrx      (portb_ddrx),
      .portx_val (portb_val),
      .ddrx_val  (ddrb_val),
      .pinx_val  (pinb_val)
   );

   timer_counter0 timer_counter0_inst (
      .cp2      (cp2),
      .reset    (reset),
      .dbus_in  (dbus_in),
      .tccr_wr  (wr_sel[REG_TCCR0]),
      .tcnt_wr  (wr_sel[REG_TCNT0]),
      .ocr_wr   (wr_sel[REG_OCR0]),
      .tifr_wr  (wr_sel[REG_TIFR]),
      .ovf_ack  (irq_ack[IRQ_TC0_OVF]),
      .cmp_ack  (irq_ack[IRQ_TC0_CMP]),
      .tccr_val (tccr0_val),
      .tcnt_val (tcnt0_val),
      .ocr_val  (ocr0_val),
      .tifr_val (tifr_val),
      .ovf_irq  (tc0_ovf_irq),
      .cmp_irq  (tc0_cmp_irq)
   );

   // =========================================================================
   // Read data merge
   // =========================================================================

   io_read_mux io_read_mux_inst (
      .rd_sel    (rd_sel),
      .porta_val (porta_val),
      .ddra_val  (ddra_val),
      .pina_val  (pina_val),
      .portb_val (portb_val),
      .ddrb_val  (ddrb_val),
      .pinb_val  (pinb_val),
      .tccr0_val (tccr0_val),
      .tcnt0_val (tcnt0_val),
      .ocr0_val  (ocr0_val),
      .tifr_val  (tifr_val),
      .dbus_out  (dbus_out),
      .out_en    (out_en)
   );

   // Interrupt vector, unused lines stay low
   always_comb begin
      irqlines              = '0;
      irqlines[IRQ_TC0_OVF] = tc0_ovf_irq;
      irqlines[IRQ_TC0_CMP] = tc0_cmp_irq;
      irqlines[IRQ_EXT1]    = ext_irq1;
   end

endmodule

// File: source/pport.sv
module pport #(
   parameter int port_width = 8
) (
   input  logic                  cp2,
   input  logic                  reset,
   input  avr_io_pkg::io_data_t  dbus_in,
   input  logic                  portx_wr,
   input  logic                  ddrx_wr,
   input  logic [port_width-1:0] pinx,
   output logic [port_width-1:0] portx,
   output logic [port_width-1:0] ddrx,
   output avr_io_pkg::io_data_t  portx_val,
   output avr_io_pkg::io_data_t  ddrx_val,
   output avr_io_pkg::io_data_t  pinx_val
);

   import avr_io_pkg::*;

   logic [port_width-1:0] pin_meta;
   logic [port_width-1:0] pin_sync;

   // =========================================================================
   // Output and direction registers
   // =========================================================================

   always_ff @(posedge cp2) begin
      if (reset) begin
         portx <= '0;
      end else if (portx_wr) begin
         portx <= dbus_in[port_width-1:0];
      end
   end

   always_ff @(posedge cp2) begin
      if (reset) begin
         ddrx <= '0;
      end else if (ddrx_wr) begin
         ddrx <= dbus_in[port_width-1:0];
      end
   end

   // =========================================================================
   // Pin synchronizer
   // =========================================================================

   // Two stages, the pins are asynchronous to cp2
   always_ff @(posedge cp2) begin
      if (reset) begin
         pin_meta <= '0;
         pin_sync <= '0;
      end else begin
         pin_meta <= pinx;
         pin_sync <= pin_meta;
      end
   end

   // Read values, upper bits zero for narrow ports
   assign portx_val = io_data_t'(portx);
   assign ddrx_val  = io_data_t'(ddrx);
   assign pinx_val  = io_data_t'(pin_sync);

endmodule

// File: source/timer_counter0.sv
module timer_counter0 (
   input  logic                 cp2,
   input  logic                 reset,
   input  avr_io_pkg::io_data_t dbus_in,
   input  logic                 tccr_wr,
   input  logic                 tcnt_wr,
   input  logic                 ocr_wr,
   input  logic                 tifr_wr,
   input  logic                 ovf_ack,
   input  logic                 cmp_ack,
   output avr_io_pkg::io_data_t tccr_val,
   output avr_io_pkg::io_data_t tcnt_val,
   output avr_io_pkg::io_data_t ocr_val,
   output avr_io_pkg::io_data_t tifr_val,
   output logic                 ovf_irq,
   output logic                 cmp_irq
);

   import avr_io_pkg::*;

   localparam int PRESC_WIDTH = 10;

   logic [2:0]             cs_q;
   logic [PRESC_WIDTH-1:0] presc_cnt;
   logic                   timer_on;
   logic                   cnt_en;
   io_data_t               tcnt_q;
   io_data_t               tcnt_next;
   io_data_t               ocr_q;
   logic                   tov_q;
   logic                   ocf_q;
   logic                   ovf_set;
   logic                   cmp_set;
   logic                   tov_clr;
   logic                   ocf_clr;

   // =========================================================================
   // Control and compare registers
   // =========================================================================

   always_ff @(posedge cp2) begin
      if (reset) begin
         cs_q  <= '0;
         ocr_q <= '0;
      end else begin
         if (tccr_wr) begin
            cs_q <= dbus_in[2:0];
         end
         if (ocr_wr) begin
            ocr_q <= dbus_in;
         end
      end
   end

   // =========================================================================
   // Prescaler
   // =========================================================================

   // Tap selection, codes 6 and 7 fall into the default
   always_comb begin
      timer_on = 1'b1;
      case (clk_sel_e'(cs_q))
         CS_DIV1:    cnt_en = 1'b1;
         CS_DIV8:    cnt_en = &presc_cnt[2:0];
         CS_DIV64:   cnt_en = &presc_cnt[5:0];
         CS_DIV256:  cnt_en = &presc_cnt[7:0];
         CS_DIV1024: cnt_en = &presc_cnt;
         default: begin
            timer_on = 1'b0;
            cnt_en   = 1'b0;
         end
      endcase
   end

   // A TCNT0 write restarts the division
   always_ff @(posedge cp2) begin
      if (reset || tcnt_wr || !timer_on) begin
         presc_cnt <= '0;
      end else begin
         presc_cnt <= presc_cnt + 1'b1;
      end
   end

   // =========================================================================
   // Counter and flags
   // =========================================================================

   assign tcnt_next = tcnt_q + 1'b1;

   always_ff @(posedge cp2) begin
      if (reset) begin
         tcnt_q <= '0;
      end else if (tcnt_wr) begin
         tcnt_q <= dbus_in;
      end else if (cnt_en) begin
         tcnt_q <= tcnt_next;
      end
   end

   assign ovf_set = cnt_en & ~tcnt_wr & (tcnt_q == 8'hFF);
   assign cmp_set = cnt_en & ~tcnt_wr & (tcnt_next == ocr_q);
   assign tov_clr = ovf_ack | (tifr_wr & dbus_in[TOV0_BIT]);
   assign ocf_clr = cmp_ack | (tifr_wr & dbus_in[OCF0_BIT]);

   // Set has priority over clear
   always_ff @(posedge cp2) begin
      if (reset) begin
         tov_q <= 1'b0;
         ocf_q <= 1'b0;
      end else begin
         tov_q <= ovf_set | (tov_q & ~tov_clr);
         ocf_q <= cmp_set | (ocf_q & ~ocf_clr);
      end
   end

   always_comb begin
      tifr_val           = '0;
      tifr_val[TOV0_BIT] = tov_q;
      tifr_val[OCF0_BIT] = ocf_q;
   end

   assign tccr_val = io_data_t'(cs_q);
   assign tcnt_val = tcnt_q;
   assign ocr_val  = ocr_q;
   assign ovf_irq  = tov_q;
   assign cmp_irq  = ocf_q;

endmodule
